// File: compile.f
+incdir+include
rtl/kd_pkg.sv
rtl/kd_apb_config.sv
rtl/kd_level_stage.sv
rtl/kd_tree_search.sv
testbench/kd_tree_search_tb.sv

// File: rtl/kd_apb_config.sv
`default_nettype none

// APB slave for node split data, zero wait states
module kd_apb_config (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [kd_pkg::APB_ADDR_W-1:0]   paddr,
  input  logic [kd_pkg::APB_DATA_W-1:0]   pwdata,
  output logic [kd_pkg::APB_DATA_W-1:0]   prdata,
  output logic                            pready,
  output logic                            pslverr,
  output kd_pkg::node_wr_t                node_wr,
  output kd_pkg::node_idx_t               rd_node,
  input  kd_pkg::node_cfg_t [kd_pkg::TREE_DEPTH-1:0] rd_cfg_all  // One entry per level
);

  import kd_pkg::*;

  node_idx_t addr_node;  // Node number decoded from the byte address
  logic      setup_ph;   // First cycle of a transfer
  logic      access_ph;  // Second cycle of a transfer
  logic      bad_node;   // Node 63 does not exist
  node_cfg_t rd_or;      // Read data merged over all levels
  logic      pready_q;
  logic      pslverr_q;

  assign addr_node = paddr[NODE_ADDR_LSB +: NODE_IDX_W];
  assign setup_ph  = psel & ~penable;
  assign access_ph = psel & penable;
  assign bad_node  = (addr_node == node_idx_t'(NODE_COUNT));

  // Write broadcast, fires on the access cycle only
  always_comb begin
    node_wr            = '0;
    node_wr.en         = access_ph & pwrite & ~bad_node;  // Bad address drops the write
    node_wr.node       = addr_node;
    node_wr.cfg.median = pwdata[APB_MED_LSB +: COORD_W];
    node_wr.cfg.dim    = pwdata[APB_DIM_LSB +: DIM_W];
  end

  assign rd_node = addr_node;  // Every level looks up this node

  // At most one level owns the node, the rest return zero
  always_comb begin
    rd_or = '0;
    for (int l = 0; l < TREE_DEPTH; l++) begin
      rd_or = node_cfg_t'(rd_or | rd_cfg_all[l]);
    end
  end

  // Pack into APB layout during a read access, zero otherwise
  always_comb begin
    prdata = '0;
    if (access_ph && !pwrite) begin
      prdata[APB_MED_LSB +: COORD_W] = rd_or.median;
      prdata[APB_DIM_LSB +: DIM_W]   = rd_or.dim;
    end
  end

  // Response is set up during the setup cycle so it is ready in the access cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= setup_ph;             // Access phase always completes at once
      pslverr_q <= setup_ph & bad_node;  // Clears again after the access cycle
    end
  end

  assign pready  = pready_q;
  assign pslverr = pslverr_q;

endmodule

`default_nettype wire

// File: rtl/kd_level_stage.sv
`default_nettype none

// One tree level, holds its nodes and makes one path decision per cycle
module kd_level_stage #(
  parameter int LEVEL = 0  // 0 is the root level
) (
  input  logic               clk,
  input  logic               rst_n,
  input  kd_pkg::node_wr_t   node_wr,
  input  kd_pkg::node_idx_t  rd_node,
  input  logic               in_valid,
  input  kd_pkg::patch_t     in_patch,
  input  kd_pkg::leaf_idx_t  in_path,   // Only the low LEVEL bits are meaningful
  output kd_pkg::node_cfg_t  rd_cfg,
  output logic               out_valid,
  output kd_pkg::patch_t     out_patch,
  output kd_pkg::leaf_idx_t  out_path
);

  import kd_pkg::*;

  localparam int NODES = 1 << LEVEL;  // Nodes on this level
  localparam int BASE  = NODES - 1;   // Heap number of the leftmost node

  node_cfg_t cfg_q [NODES];  // Split data per node, local index 0 is leftmost
  leaf_idx_t sel_path;       // Path bits that pick the node
  node_cfg_t sel_cfg;        // Node chosen by the path so far
  coord_t    sel_coord;      // Sliced query coordinate
  coord_t    sel_median;
  logic      go_right;       // New path bit

  // Node storage, written from the APB broadcast
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NODES; i++) begin
        cfg_q[i].dim    <= dim_t'(DIM_INVALID);  // No split yet
        cfg_q[i].median <= '0;
      end
    end else begin
      for (int i = 0; i < NODES; i++) begin
        if (node_wr.en && node_wr.node == node_idx_t'(BASE + i)) begin
          cfg_q[i] <= node_wr.cfg;
        end
      end
    end
  end

  // Read-back lookup, zero when the node lives on another level
  always_comb begin
    rd_cfg = '0;
    for (int i = 0; i < NODES; i++) begin
      if (rd_node == node_idx_t'(BASE + i)) begin
        rd_cfg = cfg_q[i];
      end
    end
  end

  // Mask off anything above the bits this level owns
  assign sel_path = in_path & leaf_idx_t'(NODES - 1);

  // Node select by path
  always_comb begin
    sel_cfg = cfg_q[0];
    for (int i = 0; i < NODES; i++) begin
      if (sel_path == leaf_idx_t'(i)) begin
        sel_cfg = cfg_q[i];
      end
    end
  end

  // Slice the split coordinate
  always_comb begin
    sel_coord = '0;  // Invalid dimension compares as zero
    for (int d = 0; d < PATCH_DIMS; d++) begin
      if (sel_cfg.dim == dim_t'(d)) begin
        sel_coord = coord_t'(in_patch[d*COORD_W +: COORD_W]);
      end
    end
  end

  assign sel_median = sel_cfg.median;
  assign go_right   = !(sel_coord < sel_median);  // Both signed, ties go right

  // Valid flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Path resets so the leaf output reads zero until the first result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_path <= '0;
    end else if (in_valid) begin
      out_path <= {in_path[TREE_DEPTH-2:0], go_right};  // Append below earlier decisions
    end
  end

  // Patch payload, carried along for the next level
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_patch <= in_patch;
    end
  end

endmodule

`default_nettype wire

// File: rtl/kd_pkg.sv
`default_nettype none

package kd_pkg;

  // Tree geometry
  localparam int TREE_DEPTH = 6;   // Internal levels, also the pipeline latency
  localparam int NODE_COUNT = 63;  // Internal nodes in heap order, root is node 0
  localparam int NODE_IDX_W = 6;   // Bits of a heap node number

  // Patch geometry
  localparam int PATCH_DIMS = 5;   // Coordinates per patch
  localparam int COORD_W    = 11;  // Bits per signed coordinate
  localparam int DIM_W      = 3;   // Bits of a split dimension
  localparam int DIM_INVALID = 7;  // Reset dimension, slices a zero coordinate

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // APB data layout for one node
  // Median in bits 10..0, dimension in bits 18..16, all other bits zero
  // Byte address, node number in paddr bits 7..2
  localparam int APB_MED_LSB   = 0;
  localparam int APB_DIM_LSB   = 16;
  localparam int NODE_ADDR_LSB = 2;

  typedef logic signed [COORD_W-1:0] coord_t;  // One coordinate

  // Coordinate d in bits 11*d+10 .. 11*d, dimension 0 at the bottom
  typedef logic [PATCH_DIMS*COORD_W-1:0] patch_t;

  typedef logic [DIM_W-1:0]      dim_t;       // Split dimension, 5 and up is invalid
  typedef logic [TREE_DEPTH-1:0] leaf_idx_t;  // Leaf index, same as the full path
  typedef logic [NODE_IDX_W-1:0] node_idx_t;  // Heap node number 0..62

  // Split data held by one internal node
  typedef struct packed {
    dim_t   dim;
    coord_t median;
  } node_cfg_t;

  // Node write broadcast from the APB slave to every level
  typedef struct packed {
    logic      en;    // One cycle, at the end of a write access
    node_idx_t node;  // Heap node number
    node_cfg_t cfg;   // New split data
  } node_wr_t;

endpackage

`default_nettype wire

// File: rtl/kd_tree_search.sv
`default_nettype none

// k-d tree search top, APB config slave plus six pipelined levels
module kd_tree_search (
  input  logic                           clk,
  input  logic                           rst_n,
  // APB slave
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [kd_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic [kd_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [kd_pkg::APB_DATA_W-1:0]  prdata,
  output logic                           pready,
  output logic                           pslverr,
  // Query in, leaf out after TREE_DEPTH cycles
  input  logic                           query_valid,
  input  kd_pkg::patch_t                 query_patch,
  output logic                           result_valid,
  output kd_pkg::leaf_idx_t              result_leaf
);

  import kd_pkg::*;

  node_wr_t  node_wr;                        // Write broadcast to all levels
  node_idx_t rd_node;                        // Read lookup address
  node_cfg_t [TREE_DEPTH-1:0] rd_cfg_all;    // Read data from each level

  // Pipeline links, entry 0 is the query input
  logic      valid_chain [TREE_DEPTH+1];
  patch_t    patch_chain [TREE_DEPTH+1];
  leaf_idx_t path_chain  [TREE_DEPTH+1];

  kd_apb_config i_apb_config (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .node_wr    (node_wr),
    .rd_node    (rd_node),
    .rd_cfg_all (rd_cfg_all)
  );

  assign valid_chain[0] = query_valid;
  assign patch_chain[0] = query_patch;
  assign path_chain[0]  = '0;  // Root starts with an empty path

  for (genvar g = 0; g < TREE_DEPTH; g++) begin : g_level
    kd_level_stage #(
      .LEVEL (g)
    ) i_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .node_wr   (node_wr),
      .rd_node   (rd_node),
      .in_valid  (valid_chain[g]),
      .in_patch  (patch_chain[g]),
      .in_path   (path_chain[g]),
      .rd_cfg    (rd_cfg_all[g]),
      .out_valid (valid_chain[g+1]),
      .out_patch (patch_chain[g+1]),
      .out_path  (path_chain[g+1])
    );
  end

  // Last level's path is the leaf, its patch copy goes nowhere
  assign result_valid = valid_chain[TREE_DEPTH];
  assign result_leaf  = path_chain[TREE_DEPTH];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the k-d tree search testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --top-module kd_tree_search_tb \
    -f compile.f -Mdir "$OBJ_DIR" -o kd_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$OBJ_DIR/kd_sim" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qx "All tests passed" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: include/kd_tb_tasks.svh
`ifndef KD_TB_TASKS_SVH
`define KD_TB_TASKS_SVH

// Reference copy of the node storage, kept in step with every APB write
node_cfg_t model [NODE_COUNT];

// Reset contents, no split anywhere
function automatic void model_reset();
  for (int n = 0; n < NODE_COUNT; n++) begin
    model[n].dim    = dim_t'(DIM_INVALID);
    model[n].median = '0;
  end
endfunction

// APB word for one node, median low and dimension at bit 16
function automatic logic [31:0] apb_data(input dim_t dim, input coord_t median);
  return {13'b0, dim, 5'b0, median};
endfunction

// Access phase wait, samples a quarter period after the falling edge
task automatic wait_access();
  int n;
  n = 0;
  #(SAMPLE_DLY);
  while (!pready && n < APB_TIMEOUT) begin
    @(negedge clk);
    #(SAMPLE_DLY);
    n++;
  end
  if (!pready) begin
    $display("APB timeout: pready stayed low for %0d cycles at time %0t", n, $time);
    timeouts++;
  end
endtask

// One APB transfer, starts and ends on a falling edge
task automatic apb_xfer(input logic wr, input int node, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
  psel    = 1'b1;  // Setup cycle
  penable = 1'b0;
  pwrite  = wr;
  paddr   = 8'(node << 2);  // Byte address
  pwdata  = wr ? wdata : '0;
  @(negedge clk);
  penable = 1'b1;  // Access cycle
  wait_access();
  rdata = prdata;
  err   = pslverr;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

// Write one node and mirror it in the model
task automatic set_node(input int node, input dim_t dim, input coord_t median);
  logic [31:0] rdata;
  logic        err;
  apb_xfer(1'b1, node, apb_data(dim, median), rdata, err);
  if (err !== 1'b0) begin
    $display("** Error @ %0t: pslverr on write to node %0d", $time, node);
    errors++;
  end
  model[node].dim    = dim;
  model[node].median = median;
endtask

// Read one node back and compare with the model
task automatic check_node(input int node);
  logic [31:0] rdata;
  logic        err;
  apb_xfer(1'b0, node, '0, rdata, err);
  if (err !== 1'b0) begin
    $display("** Error @ %0t: pslverr on read of node %0d", $time, node);
    errors++;
  end
  if (rdata !== apb_data(model[node].dim, model[node].median)) begin
    $display("** Error @ %0t: node %0d read %h, expected %h", $time, node, rdata,
             apb_data(model[node].dim, model[node].median));
    errors++;
  end
endtask

// Walk the model from the root, node 2^L-1+p at level L
function automatic leaf_idx_t predict_leaf(input patch_t p);
  int     pos;
  int     node;
  coord_t c;
  pos = 0;
  for (int l = 0; l < TREE_DEPTH; l++) begin
    node = (1 << l) - 1 + pos;
    c    = '0;  // Dimension 5 and up slices zero
    if (int'(model[node].dim) < PATCH_DIMS) begin
      c = p[int'(model[node].dim) * COORD_W +: COORD_W];
    end
    pos = pos * 2 + ((int'(c) < int'(model[node].median)) ? 0 : 1);
  end
  return leaf_idx_t'(pos);
endfunction

`endif

// File: testbench/kd_tree_search_tb.sv
`default_nettype none

module kd_tree_search_tb;

  import kd_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int SAMPLE_DLY     = CLK_PERIOD / 4;
  localparam int APB_TIMEOUT    = 16;   // Cycles
  localparam int RESULT_TIMEOUT = 100;  // Cycles

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        query_valid;
  patch_t      query_patch;
  logic        result_valid;
  leaf_idx_t   result_leaf;

  int        errors   = 0;
  int        timeouts = 0;
  int        cyc      = 0;  // Rising edges so far
  leaf_idx_t exp_leaf_q [$];  // Expected leaves in query order
  int        exp_cyc_q  [$];  // Cycle each result is due

  `include "kd_tb_tasks.svh"

  kd_tree_search i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .query_valid  (query_valid),
    .query_patch  (query_patch),
    .result_valid (result_valid),
    .result_leaf  (result_leaf)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc++;

  // Result checker, outputs are registered so the falling edge is safe
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_leaf_q.size() == 0) begin
        $display("Unexpected result: leaf %0d with no query pending at %0t", result_leaf, $time);
        errors++;
      end else begin
        if (result_leaf !== exp_leaf_q[0]) begin
          $display("** Error @ %0t: leaf %0d, expected %0d", $time, result_leaf, exp_leaf_q[0]);
          errors++;
        end
        if (cyc != exp_cyc_q[0]) begin
          $display("** Error @ %0t: result in cycle %0d, expected cycle %0d", $time, cyc,
                   exp_cyc_q[0]);
          errors++;
        end
        void'(exp_leaf_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
    end
  end

  function automatic patch_t make_patch(input coord_t c0, input coord_t c1, input coord_t c2,
                                        input coord_t c3, input coord_t c4);
    return {c4, c3, c2, c1, c0};  // Dimension 0 at the bottom
  endfunction

  function automatic patch_t rand_patch();
    return patch_t'({$urandom, $urandom});
  endfunction

  // Drive one query for one cycle with a given expected leaf
  task automatic send_query(input patch_t p, input leaf_idx_t exp_leaf);
    query_valid = 1'b1;
    query_patch = p;
    exp_leaf_q.push_back(exp_leaf);
    exp_cyc_q.push_back(cyc + TREE_DEPTH);  // Sampled on the next edge, out after six
    @(negedge clk);
    query_valid = 1'b0;
  endtask

  // Back to back calls stream, leaf comes from the model walk
  task automatic issue_query(input patch_t p);
    send_query(p, predict_leaf(p));
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (exp_leaf_q.size() != 0 && n < RESULT_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (exp_leaf_q.size() != 0) begin
      $display("Timeout: %0d results never arrived by %0t", exp_leaf_q.size(), $time);
      timeouts++;
      exp_leaf_q.delete();
      exp_cyc_q.delete();
    end
    @(negedge clk);
  endtask

  task automatic verify_reset_defaults();
    if (result_valid !== 1'b0 || result_leaf !== '0 || pready !== 1'b0 || pslverr !== 1'b0) begin
      $display("** Error @ %0t: outputs not cleared by reset", $time);
      errors++;
    end
    check_node(0);
    check_node(5);
    check_node(30);
    check_node(62);
    for (int i = 0; i < 4; i++) begin
      send_query(rand_patch(), '1);  // Zero never below a zero median, all right turns
    end
    wait_results();
  endtask

  task automatic config_readback();
    logic [31:0] rdata;
    logic        err;
    for (int n = 0; n < NODE_COUNT; n++) begin
      set_node(n, dim_t'($urandom_range(0, 4)), coord_t'($urandom));
    end
    for (int n = 0; n < NODE_COUNT; n++) begin
      check_node(n);
    end
    apb_xfer(1'b0, NODE_COUNT, '0, rdata, err);  // Node 63 does not exist
    if (err !== 1'b1) begin
      $display("** Error @ %0t: no pslverr on read of node 63", $time);
      errors++;
    end
    apb_xfer(1'b1, NODE_COUNT, 32'h0001_0123, rdata, err);
    if (err !== 1'b1) begin
      $display("** Error @ %0t: no pslverr on write to node 63", $time);
      errors++;
    end
    if (pslverr !== 1'b0) begin  // Idle again
      $display("** Error @ %0t: pslverr still high after the access", $time);
      errors++;
    end
    check_node(0);  // Write to node 63 left the tree alone
  endtask

  task automatic single_queries();
    coord_t m;
    m = model[0].median;
    issue_query(make_patch(m, m, m, m, m));
    wait_results();
    issue_query(make_patch(m - 11'sd1, m - 11'sd1, m - 11'sd1, m - 11'sd1, m - 11'sd1));
    wait_results();
    issue_query(make_patch(-11'sd5, -11'sd300, -11'sd1024, -11'sd1, -11'sd77));
    wait_results();
  endtask

  task automatic stream_random_queries();
    for (int i = 0; i < 40; i++) begin
      issue_query(rand_patch());
    end
    wait_results();
  endtask

  task automatic invalid_dim_split();
    set_node(0, dim_t'(6), -11'sd100);  // Zero coordinate is never below, goes right
    for (int i = 0; i < 8; i++) begin
      issue_query(rand_patch());
    end
    wait_results();
    set_node(0, dim_t'(6), 11'sd100);  // Zero is always below, goes left
    for (int i = 0; i < 8; i++) begin
      issue_query(rand_patch());
    end
    wait_results();
  endtask

  task automatic reconfigure_root();
    set_node(0, dim_t'(2), 11'sd0);
    for (int i = 0; i < 10; i++) begin
      issue_query(rand_patch());
    end
    wait_results();
    set_node(0, dim_t'(4), 11'sd300);
    check_node(0);
    for (int i = 0; i < 10; i++) begin
      issue_query(rand_patch());
    end
    wait_results();
  endtask

  initial begin
    void'($urandom(32'ha416_8546));
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    query_valid = 1'b0;
    query_patch = '0;
    model_reset();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    verify_reset_defaults();
    config_readback();
    single_queries();
    stream_random_queries();
    invalid_dim_split();
    reconfigure_root();
    $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
